// ==== logic/cpu_macros.svh ====
////////////////////
// Widths and reset values for the pipelined core
// Changing WORD_W alone is not supported, the decode assumes 32-bit MIPS fields
////////////////////
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Datapath and register file widths
`define WORD_W     32
`define REG_ADDR_W 5

// Instruction fields
`define OPCODE_W   6
`define FUNCT_W    6

// Fetch starts here after reset
`define PC_INIT    32'h0000_0000

`endif

// ==== logic/cpuTypesPkg.sv ====
////////////////////
// Shared types of the pipelined core
// Opcode and funct values follow MIPS, HALT is all ones
////////////////////
`include "cpu_macros.svh"

package cpuTypesPkg;

  typedef logic [`WORD_W-1:0]     word_t;
  typedef logic [`REG_ADDR_W-1:0] regAddr_t;

  // Kept subset of the MIPS opcodes
  typedef enum logic [`OPCODE_W-1:0] {
    RTYPE = 6'h00,
    J     = 6'h02,
    BEQ   = 6'h04,
    BNE   = 6'h05,
    ADDIU = 6'h09,
    ORI   = 6'h0d,
    LUI   = 6'h0f,
    LW    = 6'h23,
    SW    = 6'h2b,
    HALT  = 6'h3f
  } opcode_t;

  // R-type function codes
  typedef enum logic [`FUNCT_W-1:0] {
    ADDU = 6'h21,
    SUBU = 6'h23,
    AND  = 6'h24,
    OR   = 6'h25
  } funct_t;

  typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR} aluOp_t;

  // Operand source for the execute stage
  typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwdSel_t;

  typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE, BR_JUMP} branchType_t;

endpackage

// ==== logic/fetchStage.sv ====
////////////////////
// PC and fetch/decode register
// A flush clears the instruction to zero, which decodes as a no-op
////////////////////
`timescale 1ns/1ps
`include "cpu_macros.svh"

module fetchStage (
  input  logic               CLK,
  input  logic               nRST,
  input  logic               pcEn,
  input  logic               ifIdEn,
  input  logic               ifIdFlush,
  input  logic               redirect,
  input  cpuTypesPkg::word_t redirectPc,
  input  cpuTypesPkg::word_t imemload,
  output cpuTypesPkg::word_t imemaddr,
  output cpuTypesPkg::word_t ifInstr,
  output cpuTypesPkg::word_t ifPcInc
);
  import cpuTypesPkg::*;

  word_t pcInc;

  assign pcInc = imemaddr + 32'd4;

  // Program counter, redirect wins over sequential
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      imemaddr <= `PC_INIT;
    end else if (pcEn) begin
      imemaddr <= redirect ? redirectPc : pcInc;
    end
  end

  // Fetch/decode register
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ifInstr <= '0;
      ifPcInc <= '0;
    end else if (ifIdFlush) begin
      ifInstr <= '0;
      ifPcInc <= '0;
    end else if (ifIdEn) begin
      ifInstr <= imemload;
      ifPcInc <= pcInc;
    end
  end

  // Branch targets from execute must keep fetch word aligned
  assert property (@(posedge CLK) disable iff (!nRST) imemaddr[1:0] == 2'b00)
    else $error("fetchStage: unaligned imemaddr %h", imemaddr);

endmodule

// ==== logic/decodeStage.sv ====
////////////////////
// Decode, register file and decode/execute register
// Unknown opcodes and functs decode as bubbles
// Register file writes on the edge and bypasses the write to a same-cycle read
////////////////////
`timescale 1ns/1ps
`include "cpu_macros.svh"

module decodeStage (
  input  logic                     CLK,
  input  logic                     nRST,
  input  cpuTypesPkg::word_t       ifInstr,
  input  cpuTypesPkg::word_t       ifPcInc,
  input  logic                     idExEn,
  input  logic                     idExFlush,
  input  logic                     wbWrite,
  input  cpuTypesPkg::regAddr_t    wbDest,
  input  cpuTypesPkg::word_t       wbData,
  output cpuTypesPkg::regAddr_t    idRs,
  output cpuTypesPkg::regAddr_t    idRt,
  output cpuTypesPkg::aluOp_t      exAluOp,
  output logic                     exUseImm,
  output logic                     exLui,
  output cpuTypesPkg::branchType_t exBranch,
  output logic                     exRegWrite,
  output logic                     exMemRead,
  output logic                     exMemWrite,
  output logic                     exHalt,
  output cpuTypesPkg::regAddr_t    exRs,
  output cpuTypesPkg::regAddr_t    exRt,
  output cpuTypesPkg::regAddr_t    exDest,
  output cpuTypesPkg::word_t       exBusA,
  output cpuTypesPkg::word_t       exBusB,
  output cpuTypesPkg::word_t       exImm,
  output cpuTypesPkg::word_t       exPcInc,
  output cpuTypesPkg::word_t       exJumpTarget
);
  import cpuTypesPkg::*;

  opcode_t opcode;
  funct_t funct;
  regAddr_t rd;
  aluOp_t aluOp;
  branchType_t branch;
  logic useImm, lui, regWrite, memRead, memWrite, isHalt, zeroExt;
  regAddr_t dest;
  word_t imm, jumpTarget;
  word_t regFile [2**`REG_ADDR_W];

  // Register 0 reads zero, a pending write shows through
  function automatic word_t readReg(regAddr_t sel);
    if (sel == '0) begin
      return '0;
    end else if (wbWrite && (wbDest == sel)) begin
      return wbData;
    end
    return regFile[sel];
  endfunction

  // Instruction fields
  assign opcode = opcode_t'(ifInstr[31:26]);
  assign funct  = funct_t'(ifInstr[5:0]);
  assign idRs   = ifInstr[25:21];
  assign idRt   = ifInstr[20:16];
  assign rd     = ifInstr[15:11];

  ////////////////////
  // Control decode
  always_comb begin
    aluOp    = ALU_ADD;
    branch   = BR_NONE;
    useImm   = 1'b0;
    lui      = 1'b0;
    regWrite = 1'b0;
    memRead  = 1'b0;
    memWrite = 1'b0;
    isHalt   = 1'b0;
    zeroExt  = 1'b0;
    dest     = idRt;
    case (opcode)
      RTYPE: begin
        dest     = rd;
        regWrite = 1'b1;
        case (funct)
          ADDU:    aluOp = ALU_ADD;
          SUBU:    aluOp = ALU_SUB;
          AND:     aluOp = ALU_AND;
          OR:      aluOp = ALU_OR;
          default: regWrite = 1'b0;
        endcase
      end
      ADDIU: begin
        useImm   = 1'b1;
        regWrite = 1'b1;
      end
      ORI: begin
        aluOp    = ALU_OR;
        useImm   = 1'b1;
        zeroExt  = 1'b1;
        regWrite = 1'b1;
      end
      LUI: begin
        lui      = 1'b1;
        regWrite = 1'b1;
      end
      LW: begin
        useImm   = 1'b1;
        regWrite = 1'b1;
        memRead  = 1'b1;
      end
      SW: begin
        useImm   = 1'b1;
        memWrite = 1'b1;
      end
      BEQ:     branch = BR_EQ;
      BNE:     branch = BR_NE;
      J:       branch = BR_JUMP;
      HALT:    isHalt = 1'b1;
      default: ;
    endcase
  end

  // Only ORI zero-extends
  assign imm = zeroExt ? {16'h0000, ifInstr[15:0]} : {{16{ifInstr[15]}}, ifInstr[15:0]};

  // Upper PC bits plus index
  assign jumpTarget = {ifPcInc[31:28], ifInstr[25:0], 2'b00};

  // Register file, no reset
  always_ff @(posedge CLK) begin
    if (wbWrite && (wbDest != '0)) begin
      regFile[wbDest] <= wbData;
    end
  end

  ////////////////////
  // Decode/execute register, control part
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      exAluOp    <= ALU_ADD;
      exBranch   <= BR_NONE;
      exUseImm   <= 1'b0;
      exLui      <= 1'b0;
      exRegWrite <= 1'b0;
      exMemRead  <= 1'b0;
      exMemWrite <= 1'b0;
      exHalt     <= 1'b0;
      exRs       <= '0;
      exRt       <= '0;
      exDest     <= '0;
    end else if (idExFlush) begin
      // Bubble
      exAluOp    <= ALU_ADD;
      exBranch   <= BR_NONE;
      exUseImm   <= 1'b0;
      exLui      <= 1'b0;
      exRegWrite <= 1'b0;
      exMemRead  <= 1'b0;
      exMemWrite <= 1'b0;
      exHalt     <= 1'b0;
      exRs       <= '0;
      exRt       <= '0;
      exDest     <= '0;
    end else if (idExEn) begin
      exAluOp    <= aluOp;
      exBranch   <= branch;
      exUseImm   <= useImm;
      exLui      <= lui;
      exRegWrite <= regWrite;
      exMemRead  <= memRead;
      exMemWrite <= memWrite;
      exHalt     <= isHalt;
      exRs       <= idRs;
      exRt       <= idRt;
      exDest     <= dest;
    end
  end

  // Payload part
  always_ff @(posedge CLK) begin
    if (idExEn) begin
      exBusA       <= readReg(idRs);
      exBusB       <= readReg(idRt);
      exImm        <= imm;
      exPcInc      <= ifPcInc;
      exJumpTarget <= jumpTarget;
    end
  end

endmodule

// ==== logic/executeStage.sv ====
////////////////////
// Forwarding, ALU, branch resolution, execute/memory register
// Branches and jumps resolve here, two younger slots are flushed
// memResult is also the data address
////////////////////
`timescale 1ns/1ps

module executeStage (
  input  logic                     CLK,
  input  logic                     nRST,
  input  logic                     exMemEn,
  input  cpuTypesPkg::aluOp_t      exAluOp,
  input  logic                     exUseImm,
  input  logic                     exLui,
  input  cpuTypesPkg::branchType_t exBranch,
  input  logic                     exRegWrite,
  input  logic                     exMemRead,
  input  logic                     exMemWrite,
  input  logic                     exHalt,
  input  cpuTypesPkg::regAddr_t    exRs,
  input  cpuTypesPkg::regAddr_t    exRt,
  input  cpuTypesPkg::regAddr_t    exDest,
  input  cpuTypesPkg::word_t       exBusA,
  input  cpuTypesPkg::word_t       exBusB,
  input  cpuTypesPkg::word_t       exImm,
  input  cpuTypesPkg::word_t       exPcInc,
  input  cpuTypesPkg::word_t       exJumpTarget,
  input  cpuTypesPkg::fwdSel_t     fwdA,
  input  cpuTypesPkg::fwdSel_t     fwdB,
  input  cpuTypesPkg::word_t       wbData,
  output logic                     redirect,
  output cpuTypesPkg::word_t       redirectPc,
  output logic                     memRead,
  output logic                     memWrite,
  output logic                     memRegWrite,
  output logic                     memHalt,
  output cpuTypesPkg::regAddr_t    memDest,
  output cpuTypesPkg::word_t       memResult,
  output cpuTypesPkg::word_t       memStore
);
  import cpuTypesPkg::*;

  word_t opA, opB, aluB, aluOut, result;

  // Forwarding muxes, memory stage value is our own memResult
  always_comb begin
    case (fwdA)
      FWD_MEM: opA = memResult;
      FWD_WB:  opA = wbData;
      default: opA = exBusA;
    endcase
    case (fwdB)
      FWD_MEM: opB = memResult;
      FWD_WB:  opB = wbData;
      default: opB = exBusB;
    endcase
  end

  assign aluB = exUseImm ? exImm : opB;

  always_comb begin
    case (exAluOp)
      ALU_SUB: aluOut = opA - aluB;
      ALU_AND: aluOut = opA & aluB;
      ALU_OR:  aluOut = opA | aluB;
      default: aluOut = opA + aluB;
    endcase
  end

  // LUI bypasses the ALU
  assign result = exLui ? {exImm[15:0], 16'h0000} : aluOut;

  ////////////////////
  // Branch and jump resolution
  always_comb begin
    case (exBranch)
      BR_EQ:   redirect = (opA == opB);
      BR_NE:   redirect = (opA != opB);
      BR_JUMP: redirect = 1'b1;
      default: redirect = 1'b0;
    endcase
  end

  assign redirectPc = (exBranch == BR_JUMP) ? exJumpTarget : exPcInc + (exImm << 2);

  // Execute/memory register, control part
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      memRead     <= 1'b0;
      memWrite    <= 1'b0;
      memRegWrite <= 1'b0;
      memHalt     <= 1'b0;
    end else if (exMemEn) begin
      memRead     <= exMemRead;
      memWrite    <= exMemWrite;
      memRegWrite <= exRegWrite;
      memHalt     <= exHalt;
    end
  end

  // Payload, store data already forwarded
  always_ff @(posedge CLK) begin
    if (exMemEn) begin
      memDest   <= exDest;
      memResult <= result;
      memStore  <= opB;
    end
  end

  // Decode never marks one instruction as both load and store
  assert property (@(posedge CLK) disable iff (!nRST) !(memRead && memWrite))
    else $error("executeStage: load and store together at %h", memResult);

endmodule

// ==== logic/memWriteback.sv ====
////////////////////
// Memory/writeback register, writeback select and halt
// Load data is captured on the advancing edge, when dhit is high
////////////////////
`timescale 1ns/1ps

module memWriteback (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  memWbEn,
  input  logic                  memRead,
  input  logic                  memRegWrite,
  input  logic                  memHalt,
  input  cpuTypesPkg::regAddr_t memDest,
  input  cpuTypesPkg::word_t    memResult,
  input  cpuTypesPkg::word_t    dmemload,
  output logic                  wbWrite,
  output cpuTypesPkg::regAddr_t wbDest,
  output cpuTypesPkg::word_t    wbData,
  output logic                  halt
);
  import cpuTypesPkg::*;

  logic wbRead;
  word_t wbResult, wbLoad;

  // Control flags
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      wbRead  <= 1'b0;
      wbWrite <= 1'b0;
      halt    <= 1'b0;
    end else if (memWbEn) begin
      wbRead  <= memRead;
      wbWrite <= memRegWrite;
      halt    <= memHalt;
    end
  end

  // Payload
  always_ff @(posedge CLK) begin
    if (memWbEn) begin
      wbDest   <= memDest;
      wbResult <= memResult;
      wbLoad   <= dmemload;
    end
  end

  assign wbData = wbRead ? wbLoad : wbResult;

endmodule

// ==== logic/hazardUnit.sv ====
////////////////////
// Enables, flushes, load-use stall and forwarding selects
// Everything is gated by the advance condition, so a miss freezes the pipe
////////////////////
`timescale 1ns/1ps

module hazardUnit (
  input  logic                  ihit,
  input  logic                  dhit,
  input  logic                  memRead,
  input  logic                  memWrite,
  input  cpuTypesPkg::regAddr_t idRs,
  input  cpuTypesPkg::regAddr_t idRt,
  input  cpuTypesPkg::regAddr_t exRs,
  input  cpuTypesPkg::regAddr_t exRt,
  input  cpuTypesPkg::regAddr_t exDest,
  input  logic                  exMemRead,
  input  logic                  redirect,
  input  cpuTypesPkg::regAddr_t memDest,
  input  logic                  memRegWrite,
  input  cpuTypesPkg::regAddr_t wbDest,
  input  logic                  wbWrite,
  output logic                  pcEn,
  output logic                  ifIdEn,
  output logic                  ifIdFlush,
  output logic                  idExEn,
  output logic                  idExFlush,
  output logic                  exMemEn,
  output logic                  memWbEn,
  output cpuTypesPkg::fwdSel_t  fwdA,
  output cpuTypesPkg::fwdSel_t  fwdB
);
  import cpuTypesPkg::*;

  logic advance, loadUse;

  // Memory stage wins over writeback
  // r0 is never forwarded
  function automatic fwdSel_t fwdFor(regAddr_t src);
    if (src == '0) begin
      return FWD_NONE;
    end else if (memRegWrite && (memDest == src)) begin
      return FWD_MEM;
    end else if (wbWrite && (wbDest == src)) begin
      return FWD_WB;
    end
    return FWD_NONE;
  endfunction

  always_comb begin
    fwdA = fwdFor(exRs);
    fwdB = fwdFor(exRt);
  end

  // Instruction present, and data done if a request is out
  assign advance = ihit && (dhit || !(memRead || memWrite));

  // Load in execute feeding the instruction in decode
  assign loadUse = exMemRead && ((exDest == idRs) || (exDest == idRt));

  ////////////////////
  always_comb begin
    // Load-use holds PC and fetch/decode
    pcEn      = advance && !loadUse;
    ifIdEn    = advance && !loadUse;
    idExEn    = advance;
    exMemEn   = advance;
    memWbEn   = advance;
    // Taken branch kills two younger slots
    ifIdFlush = advance && redirect;
    // Load-use inserts a bubble in decode/execute
    idExFlush = advance && (redirect || loadUse);

    // Fetch/decode is never flushed while held
    assert (!(ifIdFlush && !ifIdEn))
      else $error("hazardUnit: fetch/decode flushed while held");
  end

endmodule

// ==== logic/pipeDatapath.sv ====
////////////////////
// Five-stage pipelined datapath, top level
// Pipe advances only on ihit, and on dhit while a data request is out
// Memories must hold their hit while the request is unchanged
// halt stays high once HALT reaches memory/writeback
////////////////////
`timescale 1ns/1ps

module pipeDatapath (
  input  logic               CLK,
  input  logic               nRST,
  input  cpuTypesPkg::word_t imemload,
  input  logic               ihit,
  input  cpuTypesPkg::word_t dmemload,
  input  logic               dhit,
  output cpuTypesPkg::word_t imemaddr,
  output logic               imemREN,
  output logic               dmemREN,
  output logic               dmemWEN,
  output cpuTypesPkg::word_t dmemaddr,
  output cpuTypesPkg::word_t dmemstore,
  output logic               halt
);
  import cpuTypesPkg::*;

  // Enables, flushes, forwarding
  logic pcEn, ifIdEn, ifIdFlush, idExEn, idExFlush, exMemEn, memWbEn;
  fwdSel_t fwdA, fwdB;

  // Fetch to decode
  word_t ifInstr, ifPcInc;
  regAddr_t idRs, idRt;

  // Decode/execute register
  aluOp_t exAluOp;
  branchType_t exBranch;
  logic exUseImm, exLui, exRegWrite, exMemRead, exMemWrite, exHalt;
  regAddr_t exRs, exRt, exDest;
  word_t exBusA, exBusB, exImm, exPcInc, exJumpTarget;

  // Execute/memory register and redirect
  logic redirect;
  word_t redirectPc;
  logic memRead, memWrite, memRegWrite, memHalt;
  regAddr_t memDest;
  word_t memResult, memStore;

  // Writeback feedback
  logic wbWrite;
  regAddr_t wbDest;
  word_t wbData;

  fetchStage u_fetch (.*);
  decodeStage u_decode (.*);
  executeStage u_execute (.*);
  memWriteback u_memWb (.*);
  hazardUnit u_hazard (.*);

  // Data port straight off the execute/memory register
  assign dmemREN   = memRead;
  assign dmemWEN   = memWrite;
  assign dmemaddr  = memResult;
  assign dmemstore = memStore;

  // Stop fetching once halted
  assign imemREN = ~halt;

endmodule

// ==== dv/pipeChecker.sv ====
////////////////////
// Reference model and scoreboard for the pipelined datapath
// Runs the program in order once start is high and checks every accepted load and store
// A load or store counts on an edge with its enable, dhit and ihit
// Port state is checked on every edge under reset
////////////////////
`timescale 1ns/1ps

module pipeChecker #(
  parameter int IMEM_WORDS = 128,
  parameter int DMEM_WORDS = 16
) (
  input  logic        CLK,
  input  logic        nRST,
  input  logic        start,
  input  logic        runDone,
  input  logic [31:0] imem [IMEM_WORDS],
  input  logic [31:0] dmem [DMEM_WORDS],
  input  logic        ihit,
  input  logic        dhit,
  input  logic [31:0] imemaddr,
  input  logic        imemREN,
  input  logic        dmemREN,
  input  logic        dmemWEN,
  input  logic [31:0] dmemaddr,
  input  logic [31:0] dmemstore,
  input  logic        halt,
  output int          errorCount,
  output int          checkCount,
  output logic        reportDone
);

  localparam int IA_W        = $clog2(IMEM_WORDS);
  localparam int DA_W        = $clog2(DMEM_WORDS);
  localparam int STALL_LIMIT = 50;
  localparam int MAX_STEPS   = 10000;
  localparam logic [31:0] RESET_PC = 32'h0000_0000;

  logic [31:0] modelMem [DMEM_WORDS];
  logic [31:0] expAddr [$];
  logic [31:0] expData [$];
  logic [31:0] expLoad [$];
  logic modelReady = 1'b0;
  logic haltSeen = 1'b0;
  logic reported = 1'b0;
  int errors = 0;
  int checks = 0;
  int stallCycles = 0;

  assign errorCount = errors;
  assign checkCount = checks;
  assign reportDone = reported;

  ////////////////////
  // Instruction-set model
  task automatic runModel();
    logic [31:0] regs [32];
    logic [31:0] pc, instr, sImm, zImm, rsVal, rtVal, addr;
    logic [4:0] rt, rd;
    int i, steps;
    bit running;
    for (i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    for (i = 0; i < DMEM_WORDS; i++) begin
      modelMem[i] = dmem[i];
    end
    pc = '0;
    steps = 0;
    running = 1'b1;
    while (running && steps < MAX_STEPS) begin
      instr = imem[pc[IA_W+1:2]];
      rt = instr[20:16];
      rd = instr[15:11];
      sImm = {{16{instr[15]}}, instr[15:0]};
      zImm = {16'h0000, instr[15:0]};
      rsVal = regs[instr[25:21]];
      rtVal = regs[rt];
      addr = rsVal + sImm;
      pc = pc + 32'd4;
      steps++;
      case (instr[31:26])
        6'h00: begin
          case (instr[5:0])
            6'h21:   regs[rd] = rsVal + rtVal;
            6'h23:   regs[rd] = rsVal - rtVal;
            6'h24:   regs[rd] = rsVal & rtVal;
            6'h25:   regs[rd] = rsVal | rtVal;
            default: ;
          endcase
        end
        6'h09: regs[rt] = rsVal + sImm;
        6'h0d: regs[rt] = rsVal | zImm;
        6'h0f: regs[rt] = {instr[15:0], 16'h0000};
        6'h23: begin
          regs[rt] = modelMem[addr[DA_W+1:2]];
          expLoad.push_back(addr);
        end
        6'h2b: begin
          modelMem[addr[DA_W+1:2]] = rtVal;
          expAddr.push_back(addr);
          expData.push_back(rtVal);
        end
        6'h04: if (rsVal == rtVal) pc = pc + (sImm << 2);
        6'h05: if (rsVal != rtVal) pc = pc + (sImm << 2);
        6'h02: pc = {pc[31:28], instr[25:0], 2'b00};
        6'h3f: running = 1'b0;
        default: begin
          errors++;
          $display("Model met an unknown opcode %h at %h", instr[31:26], pc - 32'd4);
        end
      endcase
      // r0 stays zero
      regs[0] = '0;
    end
    if (running) begin
      errors++;
      $display("Model did not reach HALT within %0d steps", MAX_STEPS);
    end
  endtask

  task automatic compareBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      errors++;
      $display("FAILED %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // Ports while reset is held
  task automatic checkResetState();
    checks++;
    if (imemaddr !== RESET_PC) begin
      errors++;
      $display("FAILED imemaddr: got %h, expected %h", imemaddr, RESET_PC);
    end
    compareBit("imemREN", imemREN, 1'b1);
    compareBit("dmemREN", dmemREN, 1'b0);
    compareBit("dmemWEN", dmemWEN, 1'b0);
    compareBit("halt", halt, 1'b0);
  endtask

  // One accepted store against the next model store
  task automatic checkStore();
    logic [31:0] a, d;
    checks++;
    if (expAddr.size() == 0) begin
      errors++;
      $display("Store to %h with data %h has no matching model store", dmemaddr, dmemstore);
      return;
    end
    a = expAddr.pop_front();
    d = expData.pop_front();
    if (dmemaddr !== a) begin
      errors++;
      $display("FAILED dmemaddr: got %h, expected %h", dmemaddr, a);
    end
    if (dmemstore !== d) begin
      errors++;
      $display("FAILED dmemstore: got %h, expected %h", dmemstore, d);
    end
  endtask

  // One accepted load against the next model load
  task automatic checkLoad();
    logic [31:0] a;
    checks++;
    if (expLoad.size() == 0) begin
      errors++;
      $display("Load from %h has no matching model load", dmemaddr);
      return;
    end
    a = expLoad.pop_front();
    if (dmemaddr !== a) begin
      errors++;
      $display("FAILED dmemaddr: got %h, expected %h", dmemaddr, a);
    end
  endtask

  task automatic compareMemory();
    int i;
    for (i = 0; i < DMEM_WORDS; i++) begin
      checks++;
      if (dmem[i] !== modelMem[i]) begin
        errors++;
        $display("FAILED dmem[%0d]: got %h, expected %h", i, dmem[i], modelMem[i]);
      end
    end
  endtask

  ////////////////////
  // Sampled on the rising edge before the DUT registers update
  always @(posedge CLK) begin
    if (start && !modelReady) begin
      runModel();
      modelReady = 1'b1;
    end else if (!nRST && modelReady) begin
      checkResetState();
    end else if (nRST && modelReady && !reported) begin
      if (haltSeen) begin
        if (!halt) begin
          errors++;
          $display("halt dropped after it had risen");
        end
        if (dmemWEN && dhit) begin
          errors++;
          $display("Store to %h accepted after halt", dmemaddr);
        end
      end else begin
        if (dmemWEN && dhit && ihit) begin
          checkStore();
        end
        if (dmemREN && dhit && ihit) begin
          checkLoad();
        end
        if (halt) begin
          haltSeen = 1'b1;
          checks++;
          if (expAddr.size() != 0 || expLoad.size() != 0) begin
            errors++;
            $display("halt rose with %0d model stores and %0d model loads never seen",
                     expAddr.size(), expLoad.size());
          end
        end
        // Pipe must keep advancing until halt
        if (ihit && (dhit || !(dmemREN || dmemWEN))) begin
          stallCycles = 0;
        end else begin
          stallCycles++;
          if (stallCycles == STALL_LIMIT) begin
            errors++;
            $display("Pipe made no progress for %0d cycles before halt", STALL_LIMIT);
          end
        end
      end
      if (runDone) begin
        compareMemory();
        reported = 1'b1;
      end
    end
  end

endmodule

// ==== dv/pipeDatapathTb.sv ====
////////////////////
// Testbench top for the pipelined datapath
// Random program of PROG_LEN words ending in HALT with forward-only control flow
// Memory models hold their hit while the request is unchanged
// Registers r1-r7 are seeded first as the register file has no reset
////////////////////
`timescale 1ns/1ps

module pipeDatapathTb;

  localparam int PROG_LEN       = 60;
  localparam int IMEM_WORDS     = 128;
  localparam int DMEM_WORDS     = 16;
  localparam int IA_W           = $clog2(IMEM_WORDS);
  localparam int DA_W           = $clog2(DMEM_WORDS);
  localparam int HALT_TIMEOUT   = 5000;
  localparam int REPORT_TIMEOUT = 100;
  localparam int SETTLE_CYCLES  = 20;
  localparam logic [31:0] SEED  = 32'h67d9;

  // MIPS opcodes and functs
  localparam logic [5:0] OP_RTYPE = 6'h00;
  localparam logic [5:0] OP_J     = 6'h02;
  localparam logic [5:0] OP_BEQ   = 6'h04;
  localparam logic [5:0] OP_BNE   = 6'h05;
  localparam logic [5:0] OP_ADDIU = 6'h09;
  localparam logic [5:0] OP_ORI   = 6'h0d;
  localparam logic [5:0] OP_LUI   = 6'h0f;
  localparam logic [5:0] OP_LW    = 6'h23;
  localparam logic [5:0] OP_SW    = 6'h2b;
  localparam logic [5:0] OP_HALT  = 6'h3f;
  localparam logic [5:0] F_ADDU   = 6'h21;
  localparam logic [5:0] F_SUBU   = 6'h23;
  localparam logic [5:0] F_AND    = 6'h24;
  localparam logic [5:0] F_OR     = 6'h25;

  bit CLK;
  logic nRST = 1'b0;
  logic [31:0] imemload = '0;
  logic ihit = 1'b0;
  logic [31:0] dmemload = '0;
  logic dhit = 1'b0;
  logic [31:0] imemaddr, dmemaddr, dmemstore;
  logic imemREN, dmemREN, dmemWEN, halt;

  // Memories and model state
  logic [31:0] imem [IMEM_WORDS];
  logic [31:0] dmem [DMEM_WORDS];
  logic loaded = 1'b0;
  logic [31:0] progRng = SEED;
  logic [31:0] hitRng = ~SEED;
  logic [31:0] iAddr = 32'hffff_ffff;
  logic [1:0] iDelay = 2'd0;
  logic [33:0] dLastKey = '0;
  logic [1:0] dDelay = 2'd0;
  logic dBusy = 1'b0;

  // Run control
  logic runDone = 1'b0;
  logic reportDone;
  int errorCount, checkCount;
  int waitCycles;
  int hangs = 0;

  pipeDatapath u_dut (.*);

  pipeChecker #(.IMEM_WORDS(IMEM_WORDS), .DMEM_WORDS(DMEM_WORDS)) u_checker (
    .CLK(CLK), .nRST(nRST), .start(loaded), .runDone(runDone),
    .imem(imem), .dmem(dmem),
    .ihit(ihit), .dhit(dhit), .imemaddr(imemaddr), .imemREN(imemREN),
    .dmemREN(dmemREN), .dmemWEN(dmemWEN),
    .dmemaddr(dmemaddr), .dmemstore(dmemstore), .halt(halt),
    .errorCount(errorCount), .checkCount(checkCount), .reportDone(reportDone)
  );

  initial begin
    CLK = 1'b0;
    forever begin
      #4;
      CLK = ~CLK;
    end
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Zero folds onto r7
  function automatic logic [4:0] regFrom(input logic [2:0] bits);
    return (bits == 3'd0) ? 5'd7 : {2'b00, bits};
  endfunction

  function automatic logic [5:0] functFrom(input logic [1:0] sel);
    case (sel)
      2'd0:    return F_ADDU;
      2'd1:    return F_SUBU;
      2'd2:    return F_AND;
      default: return F_OR;
    endcase
  endfunction

  ////////////////////
  // Program and data image
  task automatic loadProgram();
    logic [31:0] r;
    logic [4:0] rs, rt, rd, brRt;
    logic [15:0] offset;
    int i, k;
    for (i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = '0;
    end
    for (i = 0; i < DMEM_WORDS; i++) begin
      dmem[i] = (32'(i) * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
    end
    // ADDIU r1..r7 from r0
    for (i = 1; i < 8; i++) begin
      progRng = xorshift(progRng);
      imem[i-1] = {OP_ADDIU, 5'd0, 5'(i), progRng[15:0]};
    end
    for (i = 7; i < PROG_LEN; i++) begin
      progRng = xorshift(progRng);
      r = progRng;
      rs = regFrom(r[2:0]);
      rt = regFrom(r[5:3]);
      rd = regFrom(r[8:6]);
      brRt = (r[21:20] == 2'd0) ? rs : rt;
      offset = {10'd0, r[19:16], 2'b00};
      // Skip of 0-3 words that stops at HALT
      k = int'(r[24:23]);
      if (k > PROG_LEN - 1 - i) begin
        k = PROG_LEN - 1 - i;
      end
      case (r[12:9])
        4'd4, 4'd5:   imem[i] = {OP_ADDIU, rs, rt, r[31:16]};
        4'd6:         imem[i] = {OP_ORI, rs, rt, r[31:16]};
        4'd7:         imem[i] = {OP_LUI, 5'd0, rt, r[31:16]};
        4'd8, 4'd9:   imem[i] = {OP_LW, 5'd0, rt, offset};
        4'd10, 4'd11: imem[i] = {OP_SW, 5'd0, rt, offset};
        4'd12:        imem[i] = {OP_BEQ, rs, brRt, 16'(k)};
        4'd13:        imem[i] = {OP_BNE, rs, brRt, 16'(k)};
        4'd14:        imem[i] = {OP_J, 26'(i + 1 + k)};
        default:      imem[i] = {OP_RTYPE, rs, rt, rd, 5'd0, functFrom(r[14:13])};
      endcase
    end
    imem[PROG_LEN] = {OP_HALT, 26'd0};
  endtask

  ////////////////////
  // Memory models driven on the falling edge
  always @(negedge CLK) begin
    if (!loaded) begin
      loadProgram();
      loaded = 1'b1;
    end
    // Instruction port draws a new delay per address
    if (imemaddr !== iAddr) begin
      iAddr = imemaddr;
      hitRng = xorshift(hitRng);
      iDelay = hitRng[1:0];
    end else if (iDelay != 2'd0) begin
      iDelay = iDelay - 2'd1;
    end
    ihit = imemREN && (iDelay == 2'd0);
    imemload = imem[imemaddr[IA_W+1:2]];
    // Data port
    if (!(dmemREN || dmemWEN)) begin
      dBusy = 1'b0;
      dhit = 1'b0;
    end else begin
      if (!dBusy || ({dmemaddr, dmemREN, dmemWEN} !== dLastKey)) begin
        dBusy = 1'b1;
        dLastKey = {dmemaddr, dmemREN, dmemWEN};
        hitRng = xorshift(hitRng);
        dDelay = hitRng[1:0];
      end else if (dDelay != 2'd0) begin
        dDelay = dDelay - 2'd1;
      end
      dhit = (dDelay == 2'd0);
    end
    dmemload = dmem[dmemaddr[DA_W+1:2]];
    if (dhit && dmemWEN) begin
      dmem[dmemaddr[DA_W+1:2]] = dmemstore;
    end
  end

  ////////////////////
  // Reset, run to halt, closing report
  initial begin
    nRST = 1'b0;
    repeat (16) @(negedge CLK);
    nRST = 1'b1;
    waitCycles = 0;
    while (!halt && waitCycles < HALT_TIMEOUT) begin
      @(negedge CLK);
      waitCycles++;
    end
    if (!halt) begin
      hangs++;
      $display("Timeout: halt did not rise within %0d cycles", HALT_TIMEOUT);
    end else begin
      // Watch halt hold and no late stores
      repeat (SETTLE_CYCLES) @(negedge CLK);
      runDone = 1'b1;
      waitCycles = 0;
      while (!reportDone && waitCycles < REPORT_TIMEOUT) begin
        @(negedge CLK);
        waitCycles++;
      end
      if (!reportDone) begin
        hangs++;
        $display("Timeout: checker did not finish the memory compare");
      end
    end
    $display("Checks: %0d, errors: %0d, timeouts: %0d", checkCount, errorCount, hangs);
    if (errorCount == 0 && hangs == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== list.f ====
+incdir+logic
logic/cpuTypesPkg.sv
logic/fetchStage.sv
logic/decodeStage.sv
logic/executeStage.sv
logic/memWriteback.sv
logic/hazardUnit.sv
logic/pipeDatapath.sv
dv/pipeChecker.sv
dv/pipeDatapathTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the pipelined datapath testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module pipeDatapathTb -o pipeDatapathTb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/pipeDatapathTb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Done: no errors$" "$LOG"; then
  exit 0
fi
exit 1
